//--- verilog/l2_smi_macros.svh
/*
 * Line geometry, address split and default queue depth for the
 * L2 system memory interface
 */

`ifndef L2_SMI_MACROS_SVH
`define L2_SMI_MACROS_SVH

// 32-bit words per cache line
`define L2_LINE_WORDS 8

// a line address is the tag sitting above the set index
`define L2_SET_INDEX_WIDTH 8
`define L2_TAG_WIDTH 18

// byte offset bits below a line address on the memory bus
// (lines are spaced 64 bytes apart in system memory)
`define L2_LINE_OFFSET_WIDTH 6

// default number of entries in each request queue
`define L2_QUEUE_DEPTH 4

`endif

//--- verilog/l2_smi_pkg.sv
/*
 * Width typedefs, queue entry widths, operation encoding and
 * burst engine states for the L2 system memory interface
 */

`default_nettype none

`include "l2_smi_macros.svh"

package l2_smi_pkg;

	typedef logic [31:0] word_t;
	typedef logic [`L2_LINE_WORDS * 32 - 1:0] line_t;
	typedef logic [`L2_TAG_WIDTH + `L2_SET_INDEX_WIDTH - 1:0] line_addr_t;
	typedef logic [31:0] mem_addr_t;
	typedef logic [`L2_TAG_WIDTH - 1:0] tag_t;
	typedef logic [1:0] way_t;
	typedef logic [3:0] req_id_t;
	typedef logic [$clog2(`L2_LINE_WORDS) - 1:0] burst_idx_t;

	typedef enum logic [1:0]
	{
		OP_LOAD,
		OP_STORE,
		OP_FLUSH
	} l2_op_t;

	typedef enum logic [2:0]
	{
		IDLE,
		WRITE_SETUP,
		WRITE_BURST,
		READ_SETUP,
		READ_BURST,
		ISSUE
	} smi_state_t;

	// writeback entry is the victim address above the victim line
	localparam int WB_ENTRY_WIDTH = $bits(line_addr_t) + $bits(line_t);

	// load entry is duplicate flag, fill way, requester and line address
	localparam int LOAD_ENTRY_WIDTH = 1 + $bits(way_t) + $bits(req_id_t) + $bits(line_addr_t);

endpackage

`default_nettype wire

//--- verilog/l2_queue_if.sv
/*
 * Request queue handshake between the miss classifier, a FIFO
 * and the burst engine
 */

`timescale 1ns/1ps
`default_nettype none

interface l2_queue_if #(parameter int WIDTH = 1);

	// enqueue side
	logic enqueue;
	logic [WIDTH-1:0] enq_data;
	logic can_enqueue;

	// dequeue side, deq_data always shows the oldest entry
	logic can_dequeue;
	logic [WIDTH-1:0] deq_data;
	logic dequeue;

	modport producer
	(
		output enqueue,
		output enq_data,
		input can_enqueue
	);

	modport buffer
	(
		input enqueue,
		input enq_data,
		output can_enqueue,
		output can_dequeue,
		output deq_data,
		input dequeue
	);

	modport consumer
	(
		input can_dequeue,
		input deq_data,
		output dequeue
	);

endinterface

`default_nettype wire

//--- verilog/l2_miss_classifier.sv
/*
 * Miss classifier: decides writeback and line fill for each read
 * stage request, packs the queue entries and stalls the pipeline
 */

`timescale 1ns/1ps
`default_nettype none

`include "l2_smi_macros.svh"

module l2_miss_classifier
(
	input logic clk,
	input logic reset_i,
	input logic rd_valid_i,
	input l2_smi_pkg::l2_op_t rd_op_i,
	input l2_smi_pkg::req_id_t rd_id_i,
	input l2_smi_pkg::line_addr_t rd_address_i,
	input logic rd_cache_hit_i,
	input logic rd_has_sm_data_i,
	input logic rd_line_is_dirty_i,
	input l2_smi_pkg::tag_t rd_replace_tag_i,
	input l2_smi_pkg::way_t rd_replace_way_i,
	input l2_smi_pkg::line_t rd_victim_data_i,
	input logic duplicate_request_i,
	output logic stall_pipeline_o,
	l2_queue_if.producer wb_q,
	l2_queue_if.producer load_q
);
	import l2_smi_pkg::*;

	logic need_writeback;
	logic need_load;
	line_addr_t writeback_address;

	// a dirty victim goes out on a flush, or when memory data is about to replace it
	assign need_writeback = rd_valid_i && rd_line_is_dirty_i
		&& (rd_op_i == OP_FLUSH || rd_has_sm_data_i);

	// a miss without memory data has to fetch the line
	assign need_load = rd_valid_i && !rd_cache_hit_i && !rd_has_sm_data_i;

	// victim lives in the same set, only the tag differs
	assign writeback_address = {rd_replace_tag_i, rd_address_i[`L2_SET_INDEX_WIDTH - 1:0]};

	// either queue being full blocks both, so a writeback never enters without its load
	assign stall_pipeline_o = (need_writeback && !wb_q.can_enqueue)
		|| (need_load && !load_q.can_enqueue);

	assign wb_q.enqueue = need_writeback && !stall_pipeline_o;
	assign wb_q.enq_data = {writeback_address, rd_victim_data_i};

	assign load_q.enqueue = need_load && !stall_pipeline_o;
	assign load_q.enq_data = {duplicate_request_i, rd_replace_way_i, rd_id_i, rd_address_i};

	// the pipeline re-offers a stalled request, so nothing of it may be queued yet
	stall_blocks_enqueue: assert property (
		@(posedge clk) disable iff (reset_i)
		stall_pipeline_o |-> !wb_q.enqueue && !load_q.enqueue
	);

	// a stalled request comes back unchanged in the next cycle
	stalled_request_held: assert property (
		@(posedge clk) disable iff (reset_i)
		stall_pipeline_o |=> rd_valid_i && $stable(rd_id_i) && $stable(rd_address_i)
	);

endmodule

`default_nettype wire

//--- verilog/l2_request_fifo.sv
/*
 * Synchronous FIFO for the request queues, circular buffer with
 * occupancy count, head entry shown on the dequeue side
 */

`timescale 1ns/1ps
`default_nettype none

`include "l2_smi_macros.svh"

module l2_request_fifo
#(
	parameter int WIDTH = 1,
	parameter int DEPTH = `L2_QUEUE_DEPTH
)
(
	input logic clk,
	input logic reset_i,
	l2_queue_if.buffer q
);
	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] entries [DEPTH];
	logic [PTR_WIDTH-1:0] rd_ptr_q;
	logic [PTR_WIDTH-1:0] wr_ptr_q;
	logic [COUNT_WIDTH-1:0] count_q;

	// pointers wrap explicitly so DEPTH need not be a power of two
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign q.can_enqueue = count_q != COUNT_WIDTH'(DEPTH);
	assign q.can_dequeue = count_q != '0;
	assign q.deq_data = entries[rd_ptr_q];

	always_ff @(posedge clk)
	begin
		if (q.enqueue)
			entries[wr_ptr_q] <= q.enq_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			rd_ptr_q <= '0;
			wr_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (q.enqueue)
				wr_ptr_q <= next_ptr(wr_ptr_q);
			if (q.dequeue)
				rd_ptr_q <= next_ptr(rd_ptr_q);

			// simultaneous push and pop leaves the occupancy unchanged
			if (q.enqueue && !q.dequeue)
				count_q <= count_q + 1'b1;
			else if (q.dequeue && !q.enqueue)
				count_q <= count_q - 1'b1;
		end
	end

	// the producer has to honour can_enqueue
	no_enqueue_when_full: assert property (
		@(posedge clk) disable iff (reset_i)
		q.enqueue |-> count_q != COUNT_WIDTH'(DEPTH)
	);

	// the consumer has to honour can_dequeue
	no_dequeue_when_empty: assert property (
		@(posedge clk) disable iff (reset_i)
		q.dequeue |-> count_q != '0
	);

endmodule

`default_nettype wire

//--- verilog/l2_smi_burst_engine.sv
/*
 * Burst engine: drains writebacks before loads, moves one word per
 * memory acknowledge and returns filled lines to the pipeline
 */

`timescale 1ns/1ps
`default_nettype none

`include "l2_smi_macros.svh"

module l2_smi_burst_engine
(
	input logic clk,
	input logic reset_i,
	input logic mem_ack_i,
	input l2_smi_pkg::word_t mem_rdata_i,
	output logic mem_request_o,
	output logic mem_write_o,
	output l2_smi_pkg::mem_addr_t mem_addr_o,
	output l2_smi_pkg::word_t mem_wdata_o,
	output logic fill_valid_o,
	output l2_smi_pkg::req_id_t fill_id_o,
	output l2_smi_pkg::line_addr_t fill_address_o,
	output l2_smi_pkg::way_t fill_way_o,
	output logic fill_duplicate_o,
	output l2_smi_pkg::line_t fill_data_o,
	l2_queue_if.consumer wb_q,
	l2_queue_if.consumer load_q
);
	import l2_smi_pkg::*;

	localparam burst_idx_t LAST_WORD = burst_idx_t'(`L2_LINE_WORDS - 1);

	smi_state_t state_q;
	smi_state_t state_d;
	burst_idx_t burst_idx_q;
	burst_idx_t burst_idx_d;
	line_t line_buf_q;

	line_addr_t wb_address;
	line_t wb_data;
	line_addr_t burst_address;
	logic last_ack;

	// queue heads unpacked in the order the classifier packed them
	assign {wb_address, wb_data} = wb_q.deq_data;
	assign {fill_duplicate_o, fill_way_o, fill_id_o, fill_address_o} = load_q.deq_data;

	assign last_ack = mem_ack_i && burst_idx_q == LAST_WORD;

	always_comb
	begin
		state_d = state_q;
		burst_idx_d = burst_idx_q;

		case (state_q)
			IDLE:
			begin
				// writebacks first, otherwise a fill could read memory before the
				// dirty copy of that line has landed
				if (wb_q.can_dequeue)
					state_d = WRITE_SETUP;
				else if (load_q.can_dequeue)
					state_d = fill_duplicate_o ? ISSUE : READ_SETUP;
			end

			WRITE_SETUP:
			begin
				burst_idx_d = '0;
				state_d = WRITE_BURST;
			end

			WRITE_BURST:
			begin
				if (mem_ack_i)
					burst_idx_d = burst_idx_q + 1'b1;
				if (last_ack)
					state_d = IDLE;
			end

			READ_SETUP:
			begin
				burst_idx_d = '0;
				state_d = READ_BURST;
			end

			READ_BURST:
			begin
				if (mem_ack_i)
					burst_idx_d = burst_idx_q + 1'b1;
				if (last_ack)
					state_d = ISSUE;
			end

			// one cycle of fill_valid_o, then the load entry is gone
			ISSUE:
				state_d = IDLE;

			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			state_q <= IDLE;
			burst_idx_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			burst_idx_q <= burst_idx_d;
		end
	end

	// read words land in the line buffer at their burst position
	always_ff @(posedge clk)
	begin
		if (state_q == READ_BURST && mem_ack_i)
			line_buf_q[burst_idx_q * $bits(word_t) +: $bits(word_t)] <= mem_rdata_i;
	end

	assign mem_request_o = state_q == WRITE_BURST || state_q == READ_BURST;
	assign mem_write_o = state_q == WRITE_BURST;

	assign burst_address = mem_write_o ? wb_address : fill_address_o;
	assign mem_addr_o = {burst_address, {`L2_LINE_OFFSET_WIDTH{1'b0}}}
		+ mem_addr_t'({burst_idx_q, 2'b00});
	assign mem_wdata_o = wb_data[burst_idx_q * $bits(word_t) +: $bits(word_t)];

	assign wb_q.dequeue = state_q == WRITE_BURST && last_ack;
	assign load_q.dequeue = state_q == ISSUE;

	assign fill_valid_o = state_q == ISSUE;
	assign fill_data_o = line_buf_q;

	// the bus holds a waiting request and its address until memory answers
	request_held_stable: assert property (
		@(posedge clk) disable iff (reset_i)
		mem_request_o && !mem_ack_i |=> mem_request_o && $stable(mem_addr_o)
			&& $stable(mem_write_o)
	);

	fill_valid_one_cycle: assert property (
		@(posedge clk) disable iff (reset_i)
		fill_valid_o |=> !fill_valid_o
	);

endmodule

`default_nettype wire

//--- verilog/l2_cache_smi.sv
/*
 * L2 system memory interface top: miss classifier, writeback and
 * load queues and the burst engine
 */

`timescale 1ns/1ps
`default_nettype none

module l2_cache_smi
(
	input logic clk,
	input logic reset_i,
	input logic rd_valid_i,
	input l2_smi_pkg::l2_op_t rd_op_i,
	input l2_smi_pkg::req_id_t rd_id_i,
	input l2_smi_pkg::line_addr_t rd_address_i,
	input logic rd_cache_hit_i,
	input logic rd_has_sm_data_i,
	input logic rd_line_is_dirty_i,
	input l2_smi_pkg::tag_t rd_replace_tag_i,
	input l2_smi_pkg::way_t rd_replace_way_i,
	input l2_smi_pkg::line_t rd_victim_data_i,
	input logic duplicate_request_i,
	output logic stall_pipeline_o,
	input logic mem_ack_i,
	input l2_smi_pkg::word_t mem_rdata_i,
	output logic mem_request_o,
	output logic mem_write_o,
	output l2_smi_pkg::mem_addr_t mem_addr_o,
	output l2_smi_pkg::word_t mem_wdata_o,
	output logic fill_valid_o,
	output l2_smi_pkg::req_id_t fill_id_o,
	output l2_smi_pkg::line_addr_t fill_address_o,
	output l2_smi_pkg::way_t fill_way_o,
	output logic fill_duplicate_o,
	output l2_smi_pkg::line_t fill_data_o
);
	import l2_smi_pkg::*;

	l2_queue_if #(.WIDTH(WB_ENTRY_WIDTH)) wb_q ();
	l2_queue_if #(.WIDTH(LOAD_ENTRY_WIDTH)) load_q ();

	l2_miss_classifier u_classifier (.clk, .reset_i, .rd_valid_i, .rd_op_i, .rd_id_i,
		.rd_address_i, .rd_cache_hit_i, .rd_has_sm_data_i, .rd_line_is_dirty_i,
		.rd_replace_tag_i, .rd_replace_way_i, .rd_victim_data_i, .duplicate_request_i,
		.stall_pipeline_o, .wb_q(wb_q.producer), .load_q(load_q.producer));

	l2_request_fifo #(.WIDTH(WB_ENTRY_WIDTH)) u_wb_fifo (
		.clk,
		.reset_i,
		.q(wb_q.buffer)
	);

	l2_request_fifo #(.WIDTH(LOAD_ENTRY_WIDTH)) u_load_fifo (
		.clk,
		.reset_i,
		.q(load_q.buffer)
	);

	l2_smi_burst_engine u_burst_engine (.clk, .reset_i, .mem_ack_i, .mem_rdata_i,
		.mem_request_o, .mem_write_o, .mem_addr_o, .mem_wdata_o, .fill_valid_o,
		.fill_id_o, .fill_address_o, .fill_way_o, .fill_duplicate_o, .fill_data_o,
		.wb_q(wb_q.consumer), .load_q(load_q.consumer));

endmodule

`default_nettype wire

//--- verification/tb_l2_cache_smi.sv
/*
 * Testbench for the L2 system memory interface: clock and reset, golden file
 * reader, memory model with random acknowledge, fill and write checks, timeout
 */

`timescale 1ns/1ps
`default_nettype none

module tb_l2_cache_smi;
	import l2_smi_pkg::*;

	localparam int CYCLES_PER_REQUEST = 300;
	localparam int LINE_WORDS = $bits(line_t) / $bits(word_t);

	typedef struct packed
	{
		logic is_request;
		logic [15:0] idle;
		l2_op_t op;
		req_id_t id;
		line_addr_t addr;
		logic hit;
		logic sm_data;
		logic dirty;
		tag_t tag;
		way_t way;
		logic dup;
		line_t victim;
	} stim_t;

	typedef struct packed
	{
		req_id_t id;
		line_addr_t addr;
		way_t way;
		logic dup;
		line_t data;
	} fill_t;

	logic clk;
	logic reset_i;
	logic rd_valid_i, rd_cache_hit_i, rd_has_sm_data_i, rd_line_is_dirty_i;
	logic duplicate_request_i;
	l2_op_t rd_op_i;
	req_id_t rd_id_i;
	line_addr_t rd_address_i;
	tag_t rd_replace_tag_i;
	way_t rd_replace_way_i;
	line_t rd_victim_data_i;
	logic mem_ack_i;
	word_t mem_rdata_i;
	logic stall_pipeline_o, mem_request_o, mem_write_o, fill_valid_o, fill_duplicate_o;
	mem_addr_t mem_addr_o;
	word_t mem_wdata_o;
	req_id_t fill_id_o;
	line_addr_t fill_address_o;
	way_t fill_way_o;
	line_t fill_data_o;

	// the index takes the low tag nibble as well, so a victim and its set partner stay apart
	word_t mem [16384];
	logic [31:0] lfsr_state;
	stim_t stim [$];
	fill_t exp_fills [$];
	fill_t cur_fill;
	mem_addr_t exp_waddr [$];
	word_t exp_wdata [$];
	mem_addr_t exp_raddr [$];
	int value_errors;
	int event_errors;
	int stall_cycles;
	int cycle_count;
	int cycle_limit;
	int num_requests;
	logic first_offered;

	l2_cache_smi u_dut (.*);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
	endfunction

	function automatic logic [13:0] mem_index(input mem_addr_t a);
		return {a[17:14], a[11:2]};
	endfunction

	task automatic check_fill(input req_id_t id, input line_addr_t addr, input way_t way,
		input bit dup, input line_t data);
		if (fill_id_o !== id)
		begin
			$display("** Error at %0t: fill_id_o expected %h, got %h", $time, id, fill_id_o);
			value_errors++;
		end
		if (fill_address_o !== addr)
		begin
			$display("** Error at %0t: fill_address_o expected %h, got %h", $time, addr,
				fill_address_o);
			value_errors++;
		end
		if (fill_way_o !== way)
		begin
			$display("** Error at %0t: fill_way_o expected %h, got %h", $time, way, fill_way_o);
			value_errors++;
		end
		if (fill_duplicate_o !== dup)
		begin
			$display("** Error at %0t: fill_duplicate_o expected %h, got %h", $time, dup,
				fill_duplicate_o);
			value_errors++;
		end
		// a duplicate carries whatever the line buffer last held
		if (!dup && fill_data_o !== data)
		begin
			$display("** Error at %0t: fill_data_o expected %h, got %h", $time, data, fill_data_o);
			value_errors++;
		end
	endtask

	task automatic check_mem_write(input mem_addr_t addr, input word_t data);
		if (mem_addr_o !== addr)
		begin
			$display("** Error at %0t: mem_addr_o expected %h, got %h", $time, addr, mem_addr_o);
			value_errors++;
		end
		if (mem_wdata_o !== data)
		begin
			$display("** Error at %0t: mem_wdata_o expected %h, got %h", $time, data, mem_wdata_o);
			value_errors++;
		end
	endtask

	task automatic check_mem_read(input mem_addr_t addr);
		if (mem_addr_o !== addr)
		begin
			$display("** Error at %0t: mem_addr_o expected %h, got %h", $time, addr, mem_addr_o);
			value_errors++;
		end
	endtask

	task automatic print_summary();
		$display("value errors: %0d, event errors: %0d", value_errors, event_errors);
	endtask

	task automatic load_golden();
		int fd;
		int n;
		logic [63:0] kind;
		logic [8*256-1:0] text;
		logic [31:0] op_v, id_v, hit_v, sm_v, dirty_v, tag_v, way_v, dup_v;
		line_addr_t addr_v;
		line_t data_v;
		stim_t s;
		fill_t f;

		fd = $fopen("verification/l2_smi_golden.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the golden file verification/l2_smi_golden.txt");
			event_errors++;
			return;
		end
		n = $fscanf(fd, "%s", kind);
		while (n == 1)
		begin
			s = '0;
			case (kind)
				"#": n = $fgets(text, fd);
				"M":
				begin
					n = $fscanf(fd, "%h %h", addr_v, data_v);
					for (int k = 0; k < LINE_WORDS; k++)
						mem[mem_index({addr_v, 6'b0} + 4 * k)] = data_v[k * 32 +: 32];
				end
				"R":
				begin
					n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h", op_v, id_v, addr_v, hit_v,
						sm_v, dirty_v, tag_v, way_v, dup_v, data_v);
					s.is_request = 1'b1;
					s.op = l2_op_t'(op_v[1:0]);
					s.id = id_v[3:0];
					s.addr = addr_v;
					s.hit = hit_v[0];
					s.sm_data = sm_v[0];
					s.dirty = dirty_v[0];
					s.tag = tag_v[17:0];
					s.way = way_v[1:0];
					s.dup = dup_v[0];
					s.victim = data_v;
					stim.push_back(s);
					num_requests++;
				end
				"I":
				begin
					n = $fscanf(fd, "%d", id_v);
					s.idle = id_v[15:0];
					stim.push_back(s);
				end
				"F":
				begin
					n = $fscanf(fd, "%h %h %h %h %h", id_v, addr_v, way_v, dup_v, data_v);
					f.id = id_v[3:0];
					f.addr = addr_v;
					f.way = way_v[1:0];
					f.dup = dup_v[0];
					f.data = data_v;
					exp_fills.push_back(f);
					// a fill that is not a duplicate reads its whole line, word 0 first
					if (!f.dup)
						for (int k = 0; k < LINE_WORDS; k++)
							exp_raddr.push_back({addr_v, 6'b0} + 4 * k);
				end
				"W":
				begin
					// word k of line A sits at byte A * 64 + 4k, word 0 first
					n = $fscanf(fd, "%h %h", addr_v, data_v);
					for (int k = 0; k < LINE_WORDS; k++)
					begin
						exp_waddr.push_back({addr_v, 6'b0} + 4 * k);
						exp_wdata.push_back(data_v[k * 32 +: 32]);
					end
				end
				default:
				begin
					$display("unknown line kind %0s in the golden file", kind);
					event_errors++;
				end
			endcase
			n = $fscanf(fd, "%s", kind);
		end
		$fclose(fd);
	endtask

	task automatic offer_request(input stim_t s);
		@(negedge clk);
		first_offered = 1'b1;
		rd_valid_i = 1'b1;
		rd_op_i = s.op;
		rd_id_i = s.id;
		rd_address_i = s.addr;
		rd_cache_hit_i = s.hit;
		rd_has_sm_data_i = s.sm_data;
		rd_line_is_dirty_i = s.dirty;
		rd_replace_tag_i = s.tag;
		rd_replace_way_i = s.way;
		duplicate_request_i = s.dup;
		rd_victim_data_i = s.victim;
		@(posedge clk);
		// the pipeline holds a stalled request until the queues take it
		while (stall_pipeline_o)
		begin
			stall_cycles++;
			@(posedge clk);
		end
	endtask

	task automatic idle_for(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			rd_valid_i = 1'b0;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memory model, answers and checks on the falling edge
	always @(negedge clk)
	begin
		mem_ack_i = 1'b0;
		if (reset_i === 1'b0 && !first_offered
			&& (mem_request_o !== 1'b0 || fill_valid_o !== 1'b0))
		begin
			$display("memory request or fill raised at %0t before any request", $time);
			event_errors++;
		end
		if (!reset_i && mem_request_o === 1'b1)
		begin
			mem_ack_i = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
			if (mem_ack_i && mem_write_o)
			begin
				if (exp_waddr.size() == 0)
				begin
					$display("memory write to %h at %0t with none expected", mem_addr_o, $time);
					event_errors++;
				end
				else
					check_mem_write(exp_waddr.pop_front(), exp_wdata.pop_front());
				mem[mem_index(mem_addr_o)] = mem_wdata_o;
			end
			else if (mem_ack_i)
			begin
				if (exp_raddr.size() == 0)
				begin
					$display("memory read from %h at %0t with none expected", mem_addr_o, $time);
					event_errors++;
				end
				else
					check_mem_read(exp_raddr.pop_front());
				mem_rdata_i = mem[mem_index(mem_addr_o)];
			end
		end
		if (fill_valid_o === 1'b1)
		begin
			if (exp_fills.size() == 0)
			begin
				$display("fill for id %h at %0t with none expected", fill_id_o, $time);
				event_errors++;
			end
			else
			begin
				cur_fill = exp_fills.pop_front();
				check_fill(cur_fill.id, cur_fill.addr, cur_fill.way, cur_fill.dup, cur_fill.data);
			end
		end
	end

	initial
	begin
		cycle_count = 0;
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, %0d fills, %0d reads and %0d writes never seen",
			cycle_count, exp_fills.size(), exp_raddr.size(), exp_waddr.size());
		event_errors++;
		print_summary();
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		reset_i = 1'b1;
		rd_valid_i = 1'b0;
		rd_op_i = OP_LOAD;
		rd_id_i = '0;
		rd_address_i = '0;
		rd_cache_hit_i = 1'b0;
		rd_has_sm_data_i = 1'b0;
		rd_line_is_dirty_i = 1'b0;
		rd_replace_tag_i = '0;
		rd_replace_way_i = '0;
		rd_victim_data_i = '0;
		duplicate_request_i = 1'b0;
		mem_ack_i = 1'b0;
		mem_rdata_i = '0;
		value_errors = 0;
		event_errors = 0;
		stall_cycles = 0;
		num_requests = 0;
		first_offered = 1'b0;
		lfsr_state = 32'h03a6_430e;
		// unwritten words carry their own index, so a stray read shows where it went
		for (int i = 0; i < 16384; i++)
			mem[i] = 32'hbad0_0000 | i;
		load_golden();
		cycle_limit = CYCLES_PER_REQUEST * num_requests + 20;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;
		foreach (stim[i])
		begin
			if (stim[i].is_request)
				offer_request(stim[i]);
			else
				idle_for(stim[i].idle);
		end
		@(negedge clk);
		rd_valid_i = 1'b0;
		while (exp_fills.size() != 0 || exp_waddr.size() != 0 || exp_raddr.size() != 0)
			@(posedge clk);
		// a few more cycles catch a fill or a write that nobody expected
		repeat (20) @(negedge clk);
		if (stall_cycles == 0)
		begin
			$display("stall_pipeline_o never rose during the run of misses");
			event_errors++;
		end
		print_summary();
		if (value_errors + event_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verilog
verilog/l2_smi_pkg.sv
verilog/l2_queue_if.sv
verilog/l2_miss_classifier.sv
verilog/l2_request_fifo.sv
verilog/l2_smi_burst_engine.sv
verilog/l2_cache_smi.sv
verification/tb_l2_cache_smi.sv

//--- verification/l2_smi_golden.txt
# M line_addr data | R op id line_addr hit sm_data dirty victim_tag way dup victim_data | I cycles
# F id line_addr way dup data | W line_addr data | all hex except I, lines have word 0 rightmost
# initial memory lines
M 0000101 1a0100071a0100061a0100051a0100041a0100031a0100021a0100011a010000
M 0000606 6a0600076a0600066a0600056a0600046a0600036a0600026a0600016a060000
M 0000707 7a0700077a0700067a0700057a0700047a0700037a0700027a0700017a070000
M 0000808 8a0800078a0800068a0800058a0800048a0800038a0800028a0800018a080000
M 0000909 9a0900079a0900069a0900059a0900049a0900039a0900029a0900019a090000
M 0000a0a aa0a0007aa0a0006aa0a0005aa0a0004aa0a0003aa0a0002aa0a0001aa0a0000
# quiet start, clean miss, dirty miss with memory data and a reload of its victim
I 5
R 0 1 0000101 0 0 0 00000 1 0 0
R 0 2 0000202 0 1 1 00015 2 0 c5020007c5020006c5020005c5020004c5020003c5020002c5020001c5020000
R 0 3 0001502 0 0 0 00000 0 0 0
# dirty flush, clean flush, hit, duplicate
R 2 4 0000303 1 0 1 00027 3 0 c7030007c7030006c7030005c7030004c7030003c7030002c7030001c7030000
R 2 5 0000404 1 0 0 00000 0 0 0
R 0 6 0000505 1 0 0 00000 0 0 0
R 0 7 0000101 0 0 0 00000 0 1 0
# back to back misses that overrun the load queue
R 2 8 0000606 0 0 1 00039 1 0 c9060007c9060006c9060005c9060004c9060003c9060002c9060001c9060000
R 0 9 0000707 0 0 0 00000 2 0 0
R 0 a 0000808 0 0 0 00000 3 0 0
R 0 b 0000909 0 0 0 00000 0 0 0
R 0 c 0003906 0 0 0 00000 1 0 0
R 0 d 0000a0a 0 0 0 00000 2 0 0
# expected fills in order
F 1 0000101 1 0 1a0100071a0100061a0100051a0100041a0100031a0100021a0100011a010000
F 3 0001502 0 0 c5020007c5020006c5020005c5020004c5020003c5020002c5020001c5020000
F 7 0000101 0 1 0
F 8 0000606 1 0 6a0600076a0600066a0600056a0600046a0600036a0600026a0600016a060000
F 9 0000707 2 0 7a0700077a0700067a0700057a0700047a0700037a0700027a0700017a070000
F a 0000808 3 0 8a0800078a0800068a0800058a0800048a0800038a0800028a0800018a080000
F b 0000909 0 0 9a0900079a0900069a0900059a0900049a0900039a0900029a0900019a090000
F c 0003906 1 0 c9060007c9060006c9060005c9060004c9060003c9060002c9060001c9060000
F d 0000a0a 2 0 aa0a0007aa0a0006aa0a0005aa0a0004aa0a0003aa0a0002aa0a0001aa0a0000
# expected writebacks in order
W 0001502 c5020007c5020006c5020005c5020004c5020003c5020002c5020001c5020000
W 0002703 c7030007c7030006c7030005c7030004c7030003c7030002c7030001c7030000
W 0003906 c9060007c9060006c9060005c9060004c9060003c9060002c9060001c9060000
